/* source/bp_pkg.sv */
// Branch predictor package
// PC type, counter states, table geometry and config register map
// shared by every block of the fetch-stage predictor

`default_nettype none

package bp_pkg;

  //////////////////////////////////////////////////////////////////////
  // Addresses and table geometry
  //////////////////////////////////////////////////////////////////////
  typedef logic [15:0] pc_t;                // Byte address, instructions are 2 bytes

  localparam int INDEX_BITS  = 3;           // Index is pc[3:1]
  localparam int TABLE_DEPTH = 8;           // 2**INDEX_BITS entries per table
  localparam int TAG_BITS    = 12;          // Tag is pc[15:4]
  localparam pc_t RESET_PC   = 16'h0000;    // First fetch after reset

  //////////////////////////////////////////////////////////////////////
  // 2-bit saturating counter, bit 1 is the taken prediction
  //////////////////////////////////////////////////////////////////////
  typedef enum logic [1:0] {
    strong_not_taken = 2'b00,
    weak_not_taken   = 2'b01,
    weak_taken       = 2'b10,
    strong_taken     = 2'b11
  } pred_state_t;

  // Config register map
  typedef enum logic [0:0] {
    cfg_ctrl       = 1'b0,                  // Bit 0 enables prediction
    cfg_miss_count = 1'b1                   // Read-only miss count, write clears
  } cfg_addr_t;

endpackage

`default_nettype wire

/* source/bp_config.sv */
// Predictor configuration registers
// Holds the enable bit and a saturating 16-bit misprediction count
// that software reads back through a simple register port

`timescale 1ns/100ps
`default_nettype none

module bp_config (
  input  wire                clk,
  input  wire                rst,
  input  wire                cfg_we,        // Register write strobe
  input  wire bp_pkg::cfg_addr_t cfg_addr,  // Register select
  input  wire [15:0]         cfg_wdata,
  input  wire                mispredict,    // From resolution, one count per cycle
  output logic               enable,        // Prediction and table writes on
  output logic [15:0]        cfg_rdata
);

  import bp_pkg::*;

  logic [15:0] miss_count;                  // Saturating miss counter
  logic        count_clr;                   // Software clear of the counter

  assign count_clr = cfg_we && (cfg_addr == cfg_miss_count);

  // Control register, predictor comes up enabled
  always_ff @(posedge clk) begin
    if (rst)
      enable <= 1'b1;
    else if (cfg_we && (cfg_addr == cfg_ctrl))
      enable <= cfg_wdata[0];
  end

  // Miss counter, clear wins over a count in the same cycle
  always_ff @(posedge clk) begin
    if (rst || count_clr)
      miss_count <= 16'h0000;
    else if (mispredict && (miss_count != 16'hffff))
      miss_count <= miss_count + 16'd1;       // Stops at max
  end

  // Combinational read mux
  assign cfg_rdata = (cfg_addr == cfg_ctrl) ? {15'h0000, enable} : miss_count;

  // Counter holds at max until software clears it
  assert property (@(posedge clk) disable iff (rst)
    (miss_count == 16'hffff) && !count_clr |=> (miss_count == 16'hffff));

endmodule

`default_nettype wire

/* source/branch_history_table.sv */
// Branch history table
// Eight tagged 2-bit saturating counters, looked up combinationally
// from the fetch PC and written from the resolution block

`timescale 1ns/100ps
`default_nettype none

module branch_history_table (
  input  wire                  clk,
  input  wire                  rst,
  input  wire                  enable,      // Table writes allowed
  input  wire bp_pkg::pc_t     pc,          // Fetch PC for lookup
  input  wire                  we,          // Counter update strobe
  input  wire bp_pkg::pc_t     wr_pc,       // PC of the resolved branch
  input  wire bp_pkg::pred_state_t wr_state, // New counter value
  output logic                 hit,
  output bp_pkg::pred_state_t  state
);

  import bp_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////////////////////////
  logic [TABLE_DEPTH-1:0] valid;                       // Cleared at reset
  logic [TAG_BITS-1:0]    tags     [TABLE_DEPTH];
  pred_state_t            counters [TABLE_DEPTH];

  logic [INDEX_BITS-1:0] rd_idx;
  logic [INDEX_BITS-1:0] wr_idx;
  logic [TAG_BITS-1:0]   rd_tag;

  assign rd_idx = pc[INDEX_BITS:1];                    // pc[3:1]
  assign rd_tag = pc[15:INDEX_BITS+1];                 // pc[15:4]
  assign wr_idx = wr_pc[INDEX_BITS:1];

  // Valid bits
  always_ff @(posedge clk) begin
    if (rst)
      valid <= '0;
    else if (we && enable)
      valid[wr_idx] <= 1'b1;
  end

  // Tag and counter payload
  always_ff @(posedge clk) begin
    if (we && enable) begin
      tags[wr_idx]     <= wr_pc[15:INDEX_BITS+1];
      counters[wr_idx] <= wr_state;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Lookup
  //////////////////////////////////////////////////////////////////////
  assign hit   = valid[rd_idx] && (tags[rd_idx] == rd_tag);
  assign state = hit ? counters[rd_idx] : strong_not_taken; // Miss reads as SNT

  // Resolution only asks for a write while the predictor is on
  assert property (@(posedge clk) disable iff (rst) we |-> enable);

  // Lookup state is always a real counter value out of reset
  assert property (@(posedge clk) disable iff (rst) !$isunknown(state));

endmodule

`default_nettype wire

/* source/branch_target_buffer.sv */
// Branch target buffer
// Eight tagged target entries, looked up combinationally from the
// fetch PC and written when a branch resolves taken

`timescale 1ns/100ps
`default_nettype none

module branch_target_buffer (
  input  wire              clk,
  input  wire              rst,
  input  wire              enable,          // Table writes allowed
  input  wire bp_pkg::pc_t pc,              // Fetch PC for lookup
  input  wire              we,              // Write on taken branch
  input  wire bp_pkg::pc_t wr_pc,           // PC of the resolved branch
  input  wire bp_pkg::pc_t wr_target,       // Actual target from decode
  output logic             hit,
  output bp_pkg::pc_t      target
);

  import bp_pkg::*;

  logic [TABLE_DEPTH-1:0] valid;            // Cleared at reset
  logic [TAG_BITS-1:0]    tags    [TABLE_DEPTH];
  pc_t                    targets [TABLE_DEPTH];

  logic [INDEX_BITS-1:0] rd_idx;
  logic [INDEX_BITS-1:0] wr_idx;

  assign rd_idx = pc[INDEX_BITS:1];
  assign wr_idx = wr_pc[INDEX_BITS:1];

  always_ff @(posedge clk) begin
    if (rst)
      valid <= '0;
    else if (we && enable)
      valid[wr_idx] <= 1'b1;
  end

  // Entry payload
  always_ff @(posedge clk) begin
    if (we && enable) begin
      tags[wr_idx]    <= wr_pc[15:INDEX_BITS+1];
      targets[wr_idx] <= wr_target;
    end
  end

  // Tag compare qualified by valid, target zero on a miss
  assign hit    = valid[rd_idx] && (tags[rd_idx] == pc[15:INDEX_BITS+1]);
  assign target = hit ? targets[rd_idx] : 16'h0000;

endmodule

`default_nettype wire

/* source/branch_resolve.sv */
// Branch resolution
// Checks the decode-stage outcome against the prediction carried
// down the pipe, steps the counter and flags a redirect on a miss

`timescale 1ns/100ps
`default_nettype none

module branch_resolve (
  input  wire                      enable,
  input  wire                      resolve_valid, // Decode has a branch outcome
  input  wire bp_pkg::pc_t         id_pc,
  input  wire bp_pkg::pred_state_t id_state,
  input  wire bp_pkg::pc_t         id_target,     // PC fetched after id_pc
  input  wire                      actual_taken,
  input  wire bp_pkg::pc_t         actual_target,
  output logic                     bht_we,
  output logic                     btb_we,
  output bp_pkg::pred_state_t      next_state,
  output logic                     mispredict,
  output bp_pkg::pc_t              redirect_pc
);

  import bp_pkg::*;

  pc_t  seq_pc;                             // Fall-through address
  logic pred_was_taken;                     // Fetch followed a taken prediction
  logic wrong_taken;
  logic wrong_not_taken;

  assign seq_pc         = id_pc + 16'd2;
  assign pred_was_taken = (id_target != seq_pc);

  // Saturating step toward the real outcome
  always_comb begin
    case (id_state)
      strong_not_taken: next_state = actual_taken ? weak_not_taken : strong_not_taken;
      weak_not_taken:   next_state = actual_taken ? weak_taken     : strong_not_taken;
      weak_taken:       next_state = actual_taken ? strong_taken   : weak_not_taken;
      strong_taken:     next_state = actual_taken ? strong_taken   : weak_taken;
      default:          next_state = strong_not_taken;
    endcase
  end

  assign bht_we = resolve_valid && enable;                  // Every resolve trains
  assign btb_we = resolve_valid && enable && actual_taken;  // Target only when taken

  //////////////////////////////////////////////////////////////////////
  // Misprediction and redirect
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    wrong_taken     = pred_was_taken && !actual_taken;
    wrong_not_taken = actual_taken && (!pred_was_taken || (id_target != actual_target));
    mispredict      = resolve_valid && (wrong_taken || wrong_not_taken);
    redirect_pc     = actual_taken ? actual_target : seq_pc;
  end

endmodule

`default_nettype wire

/* source/fetch_pc.sv */
// Fetch PC
// Next-PC selection from redirect, prediction or fall-through, and the
// fetch-to-decode register carrying PC, counter state and next PC

`timescale 1ns/100ps
`default_nettype none

module fetch_pc (
  input  wire                      clk,
  input  wire                      rst,
  input  wire                      advance,      // Fetch may move on
  input  wire                      pred_taken,
  input  wire bp_pkg::pc_t         pred_target,
  input  wire bp_pkg::pred_state_t pred_state,
  input  wire                      mispredict,
  input  wire bp_pkg::pc_t         redirect_pc,
  output bp_pkg::pc_t              pc,
  output bp_pkg::pc_t              id_pc,
  output bp_pkg::pred_state_t      id_state,
  output bp_pkg::pc_t              id_target     // Address fetched after id_pc
);

  import bp_pkg::*;

  pc_t pc_plus2;
  pc_t pred_next;                           // Next PC when nothing redirects

  assign pc_plus2  = pc + 16'd2;
  assign pred_next = pred_taken ? pred_target : pc_plus2;

  // Redirect beats back-pressure
  always_ff @(posedge clk) begin
    if (rst)
      pc <= RESET_PC;
    else if (mispredict)
      pc <= redirect_pc;
    else if (advance)
      pc <= pred_next;
  end

  //////////////////////////////////////////////////////////////////////
  // Fetch to decode register
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      id_pc     <= RESET_PC;
      id_state  <= strong_not_taken;
      id_target <= RESET_PC + 16'd2;          // Matches fall-through of RESET_PC
    end else if (advance) begin
      id_pc     <= pc;
      id_state  <= pred_state;
      id_target <= pred_next;
    end
  end

endmodule

`default_nettype wire

/* source/branch_predictor_top.sv */
// Branch predictor top
// Ties the history table, target buffer, resolution, fetch PC and
// config registers together and forms the taken prediction

`timescale 1ns/100ps
`default_nettype none

module branch_predictor_top (
  input  wire                  clk,
  input  wire                  rst,
  input  wire                  advance,
  input  wire                  resolve_valid,
  input  wire                  actual_taken,
  input  wire bp_pkg::pc_t     actual_target,
  input  wire                  cfg_we,
  input  wire bp_pkg::cfg_addr_t cfg_addr,
  input  wire [15:0]           cfg_wdata,
  output bp_pkg::pc_t          pc,
  output logic                 pred_taken,
  output bp_pkg::pred_state_t  pred_state,
  output bp_pkg::pc_t          id_pc,
  output bp_pkg::pred_state_t  id_state,
  output logic                 mispredict,
  output bp_pkg::pc_t          redirect_pc,
  output logic [15:0]          cfg_rdata
);

  import bp_pkg::*;

  logic        enable;
  logic        hit_bht;
  logic        hit_btb;
  pc_t         target;                      // BTB lookup result
  pc_t         id_target;
  logic        bht_we;
  logic        btb_we;
  pred_state_t next_state;

  // Taken only with both tables hitting and counter saying taken
  assign pred_taken = enable && hit_bht && pred_state[1] && hit_btb;

  //////////////////////////////////////////////////////////////////////
  // Block instances
  //////////////////////////////////////////////////////////////////////
  branch_history_table u_bht (
    .clk(clk), .rst(rst), .enable(enable), .pc(pc),
    .we(bht_we), .wr_pc(id_pc), .wr_state(next_state),
    .hit(hit_bht), .state(pred_state)
  );

  branch_target_buffer u_btb (
    .clk(clk), .rst(rst), .enable(enable), .pc(pc),
    .we(btb_we), .wr_pc(id_pc), .wr_target(actual_target),
    .hit(hit_btb), .target(target)
  );

  branch_resolve u_resolve (
    .enable(enable), .resolve_valid(resolve_valid), .id_pc(id_pc),
    .id_state(id_state), .id_target(id_target), .actual_taken(actual_taken),
    .actual_target(actual_target), .bht_we(bht_we), .btb_we(btb_we),
    .next_state(next_state), .mispredict(mispredict), .redirect_pc(redirect_pc)
  );

  fetch_pc u_fetch (
    .clk(clk), .rst(rst), .advance(advance), .pred_taken(pred_taken),
    .pred_target(target), .pred_state(pred_state), .mispredict(mispredict),
    .redirect_pc(redirect_pc), .pc(pc), .id_pc(id_pc),
    .id_state(id_state), .id_target(id_target)
  );

  bp_config u_config (
    .clk(clk), .rst(rst), .cfg_we(cfg_we), .cfg_addr(cfg_addr),
    .cfg_wdata(cfg_wdata), .mispredict(mispredict),
    .enable(enable), .cfg_rdata(cfg_rdata)
  );

endmodule

`default_nettype wire

/* bench/bp_clock.sv */
// Testbench clock generator
// Free-running clock with a 100 ns period

`timescale 1ns/100ps
`default_nettype none

module bp_clock (
  output logic clk
);

  initial clk = 1'b0;

  always #50 clk = ~clk;                    // 50 ns high, 50 ns low

endmodule

`default_nettype wire

/* bench/bp_tb.sv */
// Branch predictor testbench
// Plays the decode stage, keeps a shadow predictor model and checks
// the DUT against it with concurrent assertions

`timescale 1ns/100ps
`default_nettype none

module bp_tb;

  import bp_pkg::*;

  logic        clk;
  logic        rst = 1'b1;
  logic        advance = 1'b1;
  logic        resolve_valid = 1'b0;
  logic        actual_taken = 1'b0;
  pc_t         actual_target = 16'h0000;
  logic        cfg_we = 1'b0;
  cfg_addr_t   cfg_addr = cfg_miss_count;   // Count stays visible most of the run
  logic [15:0] cfg_wdata = 16'h0000;

  pc_t         pc;
  logic        pred_taken;
  pred_state_t pred_state;
  pc_t         id_pc;
  pred_state_t id_state;
  logic        mispredict;
  pc_t         redirect_pc;
  logic [15:0] cfg_rdata;

  integer      seed = 78;
  int          cycle_count = 0;

  bp_clock u_clock (.clk(clk));

  branch_predictor_top dut (
    .clk(clk), .rst(rst), .advance(advance), .resolve_valid(resolve_valid),
    .actual_taken(actual_taken), .actual_target(actual_target),
    .cfg_we(cfg_we), .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata),
    .pc(pc), .pred_taken(pred_taken), .pred_state(pred_state), .id_pc(id_pc),
    .id_state(id_state), .mispredict(mispredict), .redirect_pc(redirect_pc),
    .cfg_rdata(cfg_rdata)
  );

  //////////////////////////////////////////////////////////////////////
  // Shadow model
  //////////////////////////////////////////////////////////////////////
  logic        m_vb [8];                    // History table valid, tag, counter
  logic [11:0] m_tb [8];
  pred_state_t m_cnt [8];
  logic        m_vt [8];                    // Target buffer valid, tag, target
  logic [11:0] m_tt [8];
  pc_t         m_tgt [8];
  pc_t         m_pc;
  pc_t         m_id_pc;
  pred_state_t m_id_state;
  logic        m_id_taken;                  // Fetch went down the predicted path
  pc_t         m_id_tgt;
  logic        m_en;
  logic [15:0] m_miss;

  logic        bht_hit;
  logic        btb_hit;
  pred_state_t exp_state;
  logic        exp_taken;
  pc_t         exp_target;
  logic        exp_mis;
  pc_t         exp_redirect;
  pred_state_t exp_next;
  logic [15:0] exp_rdata;

  // One saturating step toward the outcome
  function automatic pred_state_t step_counter(input pred_state_t s, input logic taken);
    if (taken)
      return (s == strong_taken) ? s : pred_state_t'(s + 2'd1);
    return (s == strong_not_taken) ? s : pred_state_t'(s - 2'd1);
  endfunction

  // Fixed branch target per PC, never the fall-through
  function automatic pc_t target_of(input pc_t p);
    if (p == 16'h000a)
      return 16'h000e;
    if (p == 16'h000e)
      return 16'h0000;                      // Loop back to the start
    return p + 16'h0110;
  endfunction

  always_comb begin
    bht_hit      = m_vb[m_pc[3:1]] && (m_tb[m_pc[3:1]] == m_pc[15:4]);
    btb_hit      = m_vt[m_pc[3:1]] && (m_tt[m_pc[3:1]] == m_pc[15:4]);
    exp_state    = bht_hit ? m_cnt[m_pc[3:1]] : strong_not_taken;
    exp_target   = m_tgt[m_pc[3:1]];
    exp_taken    = m_en && bht_hit && exp_state[1] && btb_hit;
    exp_mis      = resolve_valid && (m_id_taken ?
                   (!actual_taken || (m_id_tgt != actual_target)) : actual_taken);
    exp_redirect = actual_taken ? actual_target : m_id_pc + 16'd2;
    exp_next     = step_counter(m_id_state, actual_taken);
    exp_rdata    = (cfg_addr == cfg_ctrl) ? {15'h0000, m_en} : m_miss;
  end

  always @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 8; i++) begin
        m_vb[i] <= 1'b0;
        m_vt[i] <= 1'b0;
      end
      m_pc       <= RESET_PC;
      m_id_pc    <= RESET_PC;
      m_id_state <= strong_not_taken;
      m_id_taken <= 1'b0;
      m_id_tgt   <= 16'h0000;
      m_en       <= 1'b1;
      m_miss     <= 16'h0000;
    end else begin
      if (resolve_valid && m_en) begin      // Train at the decoded branch
        m_vb[m_id_pc[3:1]]  <= 1'b1;
        m_tb[m_id_pc[3:1]]  <= m_id_pc[15:4];
        m_cnt[m_id_pc[3:1]] <= exp_next;
        if (actual_taken) begin
          m_vt[m_id_pc[3:1]]  <= 1'b1;
          m_tt[m_id_pc[3:1]]  <= m_id_pc[15:4];
          m_tgt[m_id_pc[3:1]] <= actual_target;
        end
      end
      if (exp_mis)
        m_pc <= exp_redirect;               // Redirect even with advance low
      else if (advance)
        m_pc <= exp_taken ? exp_target : m_pc + 16'd2;
      if (advance) begin
        m_id_pc    <= m_pc;
        m_id_state <= exp_state;
        m_id_taken <= exp_taken;
        m_id_tgt   <= exp_target;
      end
      if (cfg_we && (cfg_addr == cfg_ctrl))
        m_en <= cfg_wdata[0];
      if (cfg_we && (cfg_addr == cfg_miss_count))
        m_miss <= 16'h0000;
      else if (exp_mis && (m_miss != 16'hffff))
        m_miss <= m_miss + 16'd1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////
  task automatic report_mismatch(input string name, input logic [15:0] exp,
                                 input logic [15:0] got);
    $display("Error %s expected 0x%h got 0x%h", name, exp, got);
    $display("Something failed");
    $fatal(1);
  endtask

  a_pc: assert property (@(posedge clk) disable iff (rst) pc == m_pc)
    else report_mismatch("pc", $sampled(m_pc), $sampled(pc));
  a_id_pc: assert property (@(posedge clk) disable iff (rst) id_pc == m_id_pc)
    else report_mismatch("id_pc", $sampled(m_id_pc), $sampled(id_pc));
  a_id_state: assert property (@(posedge clk) disable iff (rst) id_state == m_id_state)
    else report_mismatch("id_state", {14'h0, $sampled(m_id_state)},
                         {14'h0, $sampled(id_state)});
  a_state: assert property (@(posedge clk) disable iff (rst) pred_state == exp_state)
    else report_mismatch("pred_state", {14'h0, $sampled(exp_state)},
                         {14'h0, $sampled(pred_state)});
  a_taken: assert property (@(posedge clk) disable iff (rst) pred_taken == exp_taken)
    else report_mismatch("pred_taken", {15'h0, $sampled(exp_taken)},
                         {15'h0, $sampled(pred_taken)});
  a_mis: assert property (@(posedge clk) disable iff (rst) mispredict == exp_mis)
    else report_mismatch("mispredict", {15'h0, $sampled(exp_mis)},
                         {15'h0, $sampled(mispredict)});
  a_redirect: assert property (@(posedge clk) disable iff (rst)
    exp_mis |-> redirect_pc == exp_redirect)
    else report_mismatch("redirect_pc", $sampled(exp_redirect), $sampled(redirect_pc));
  a_rdata: assert property (@(posedge clk) disable iff (rst) cfg_rdata == exp_rdata)
    else report_mismatch("cfg_rdata", $sampled(exp_rdata), $sampled(cfg_rdata));

  //////////////////////////////////////////////////////////////////////
  // Decode-stage stimulus
  //////////////////////////////////////////////////////////////////////
  // Mode 0 trains the loop, mode 1 makes 0x000a fall through, mode 2 is random
  task automatic drive_cycle(input int mode);
    pc_t         nxt_id;
    logic [31:0] rnd;
    nxt_id = advance ? m_pc : m_id_pc;      // Branch that decode sees next cycle
    rnd    = $random(seed);
    resolve_valid <= 1'b1;
    actual_target <= target_of(nxt_id);
    case (mode)
      0: begin
        actual_taken <= (nxt_id == 16'h000a) || (nxt_id == 16'h000e);
        advance      <= 1'b1;
      end
      1: begin
        actual_taken <= (nxt_id == 16'h000e);
        advance      <= 1'b1;
      end
      default: begin
        actual_taken <= rnd[0];
        advance      <= (rnd[3:2] != 2'b00); // Stall about one cycle in four
      end
    endcase
  endtask

  task automatic run_phase(input int n, input int mode);
    repeat (n) begin
      drive_cycle(mode);
      @(posedge clk);
    end
  endtask

  task automatic write_cfg(input cfg_addr_t addr, input logic [15:0] data, input int mode);
    cfg_we    <= 1'b1;
    cfg_addr  <= addr;
    cfg_wdata <= data;
    drive_cycle(mode);
    @(posedge clk);
    cfg_we   <= 1'b0;
    cfg_addr <= cfg_miss_count;
  endtask

  initial begin
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    run_phase(80, 0);                       // Counters climb and saturate
    run_phase(60, 1);                       // 0x000a steps back down
    write_cfg(cfg_ctrl, 16'h0000, 0);       // Predictor off
    run_phase(40, 0);
    write_cfg(cfg_ctrl, 16'h0001, 0);       // Back on, old entries visible
    run_phase(40, 0);
    run_phase(150, 2);
    write_cfg(cfg_miss_count, 16'h0000, 2); // Clear the miss count
    run_phase(10, 2);
    $display("Everything OK");
    $finish;
  end

  // Run limit, about 390 cycles of tests
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= 600) begin
      $display("Timeout: the tests did not finish within 600 cycles");
      $display("Something failed");
      $fatal(1);
    end
  end

endmodule

`default_nettype wire

/* src.f */
source/bp_pkg.sv
source/bp_config.sv
source/branch_history_table.sv
source/branch_target_buffer.sv
source/branch_resolve.sv
source/fetch_pc.sv
source/branch_predictor_top.sv
bench/bp_clock.sv
bench/bp_tb.sv

/* run.sh */
#!/bin/bash
# Build and run the branch predictor testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f src.f --top-module bp_tb -Mdir obj_dir &&
out="$(./obj_dir/Vbp_tb 2>&1)"
echo "$out"
echo "$out" | grep -q "Everything OK" && echo "PASS" || { echo "FAIL"; exit 1; }
